// ==== files.f ====
source/asa_pkg.sv
source/ram_1r1w.sv
source/ras_decoder.sv
source/asa_process.sv
source/enq_formatter.sv
source/asa_top.sv
sim/tb_asa_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the asa_top testbench with Verilator, runs it and scans the log.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert -j 0 -f files.f --top-module tb_asa_top -o tb_asa_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_asa_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$log"; then
	exit 1
fi
if ! grep -q "TEST PASSED" "$log"; then
	echo "Simulation log holds no result line"
	exit 1
fi
exit 0

// ==== sim/tb_asa_top.sv ====
/*
 * Random descriptors checked against a shadow-table model of the stage.
 * Every flow policy is written and every flow action seeded before first use.
 * The topic table is taken to start empty, as a two-state simulator leaves it.
 * Same-id descriptors stay 4 cycles apart, since the DUT has no forwarding.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_asa_top;
	import asa_pkg::*;

	localparam int clk_period = 4;
	localparam int n_random = 400;
	localparam int n_desc = 64 + n_random;
	localparam int watchdog_cycles = 4 * n_desc + 200;

	typedef struct packed {
		logic valid;
		logic discard;
		logic mcast;
		logic [7:0] vec;
		logic [1:0] pri;
		logic [5:0] tid;
		logic [11:0] buf_ptr;
		logic ptr_update;
		logic pd_update;
		logic cls_valid;
		logic [5:0] cls_fid;
		logic tset_wr;
		logic [8:0] tset_waddr;
		logic [15:0] tset_wdata;
	} result_t;

	logic clk;
	logic rst_n;
	logic [31:0] current_time;
	logic [15:0] default_sub_exp_time;
	logic [2:0] supervisor_sci;
	logic [15:0] class2pri;
	logic fp_wr;
	logic [5:0] fp_waddr;
	logic [14:0] fp_wdata;
	logic proc_valid;
	pkt_kind_e proc_kind;
	logic [5:0] proc_fid;
	logic [5:0] proc_tid;
	logic [2:0] proc_rci;
	logic proc_discard;
	logic [3:0] proc_domain_id;
	logic [11:0] proc_buf_ptr;
	logic [45:0] proc_ras;
	wire classifier_valid;
	wire [5:0] classifier_fid;
	wire tset_wr;
	wire [8:0] tset_waddr;
	wire [15:0] tset_wdata;
	wire enq_req;
	wire enq_discard;
	wire enq_allow_mcast;
	wire [7:0] enq_vec;
	wire [1:0] enq_pri;
	wire [5:0] enq_tid;
	wire [11:0] enq_buf_ptr;
	wire enq_ptr_update;
	wire enq_pd_update;

	logic [14:0] fp_shadow [0:63];
	logic [9:0] fa_shadow [0:63];
	logic [7:0] ta_shadow [0:63];
	int fid_free [0:63]; // First drive cycle at which the id may be used again.
	int tid_free [0:63];
	int cycle = 0;
	int n_sent = 0;
	int n_enq = 0;
	int value_errors = 0;
	int other_errors = 0;
	result_t expect_in;
	result_t exp_pipe [0:2];
	result_t chk;
	result_t obs;

	asa_top #(.fid_nbits(6), .tid_nbits(6)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout after %0d cycles, the stimulus never finished", watchdog_cycles);
		print_counts();
		$display("TEST FAILED");
		$finish;
	end

	// Model of one descriptor. Updates the shadow tables as the DUT will at k+3.
	task automatic predict(input pkt_kind_e kind, input logic [5:0] fid, input logic [5:0] tid,
		input logic [2:0] rci, input logic disc, input logic [3:0] dom,
		input logic [11:0] bp, input logic [45:0] ras, output result_t r);
		logic [14:0] pol;
		logic [7:0] m, fvec, tvec, ta, svec, stored_vec, sup_mask;
		logic [1:0] stype, ntype;
		logic fany, tval, replay, early, upd, ef, et, eflow, vec_wr, type_wr;
		pol = fp_shadow[fid];
		m = pol[14:7];
		stype = fa_shadow[fid][9:8];
		stored_vec = fa_shadow[fid][7:0];
		ta = ta_shadow[tid];
		fvec = 8'h00;
		fany = 1'b0;
		for (int i = 0; i < 8; i++) begin
			if (!ras[10 + 4 * i + 3]) begin
				fvec[ras[10 + 4 * i +: 3]] = 1'b1;
				fany = 1'b1;
			end
		end
		tval = !ras[45];
		tvec = tval ? 8'(8'b1 << ras[44:42]) : 8'h00;
		replay = kind == pkt_replay;
		early = disc || (kind == pkt_domain_checked && dom != pol[6:3]);
		upd = !early && !replay;
		ef = ras[1];
		et = ras[0];
		ntype = ras[5] ? ras[4:3] : stype;
		vec_wr = upd && ef && ras[9:8] == 2'b11 && fany && m[mo_update_fas];
		type_wr = upd && ras[5] && m[mo_update_fas];
		eflow = ras[9] && ef && m[mo_execute_forward];
		if (replay) begin
			svec = 8'h00;
			if (stype[0] && m[mo_tsas_forward]) svec = svec | ta; // Topic or both.
			if (stype[1] && m[mo_fsas_forward]) svec = svec | stored_vec;
		end else begin
			svec = (et && m[mo_execute_forward]) ? tvec : 8'h00;
			if (eflow) svec = svec | fvec;
			if (et && m[mo_tsas_forward]) svec = svec | ta;
			if (!eflow && m[mo_fsas_forward]) svec = svec | stored_vec;
		end
		sup_mask = m[mo_forward_supervisor] ? 8'hff : ~(8'b1 << supervisor_sci);
		r = '0;
		r.valid = 1'b1;
		r.discard = early || (replay ? stype == 2'b00 : ras[1:0] == 2'b00);
		r.mcast = m[mo_multicast];
		r.vec = svec & ~(8'b1 << rci) & sup_mask;
		r.pri = class2pri[2 * pol[2:0] +: 2];
		r.tid = tid;
		r.buf_ptr = bp;
		r.ptr_update = !replay && ras[6];
		r.pd_update = !replay && m[mo_update_ppd] && ras[7];
		r.cls_valid = !ras[2];
		r.cls_fid = fid;
		r.tset_wr = upd && et && tval && m[mo_update_tas];
		if (r.tset_wr) begin
			r.tset_waddr = {tid, ras[44:42]};
			ta_shadow[tid] = ta | tvec;
		end
		if (vec_wr || type_wr)
			fa_shadow[fid] = {ntype, vec_wr ? fvec : stored_vec};
	endtask

	// Expiry uses the time that the DUT samples one edge after the descriptor.
	function automatic result_t add_expiry(input result_t r);
		logic [31:0] sum;
		result_t e;
		e = r;
		sum = current_time + {default_sub_exp_time, 16'h0000};
		if (e.tset_wr) e.tset_wdata = sum[31:16];
		return e;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++)
				exp_pipe[i] <= '0;
		end else begin
			exp_pipe[0] <= add_expiry(expect_in);
			exp_pipe[1] <= exp_pipe[0];
			exp_pipe[2] <= exp_pipe[1];
		end
	end

	assign chk = exp_pipe[2];
	assign obs = {enq_req, enq_discard, enq_allow_mcast, enq_vec, enq_pri, enq_tid, enq_buf_ptr,
		enq_ptr_update, enq_pd_update, classifier_valid, classifier_fid, tset_wr, tset_waddr,
		tset_wdata};

	always @(posedge clk) begin
		if (rst_n && enq_req)
			n_enq++;
	end

	task automatic report_diff(input int group, input result_t got, input result_t want);
		case (group)
			0: begin
				if (got.valid !== want.valid)
					$display("ERROR enq_req got %h expected %h", got.valid, want.valid);
				if (got.cls_valid !== want.cls_valid)
					$display("ERROR classifier_valid got %h expected %h",
						got.cls_valid, want.cls_valid);
				if (got.tset_wr !== want.tset_wr)
					$display("ERROR tset_wr got %h expected %h", got.tset_wr, want.tset_wr);
			end
			1: begin
				if (got.discard !== want.discard)
					$display("ERROR enq_discard got %h expected %h",
						got.discard, want.discard);
				if (got.mcast !== want.mcast)
					$display("ERROR enq_allow_mcast got %h expected %h",
						got.mcast, want.mcast);
				if (got.vec !== want.vec)
					$display("ERROR enq_vec got %h expected %h", got.vec, want.vec);
				if (got.pri !== want.pri)
					$display("ERROR enq_pri got %h expected %h", got.pri, want.pri);
				if (got.tid !== want.tid)
					$display("ERROR enq_tid got %h expected %h", got.tid, want.tid);
				if (got.buf_ptr !== want.buf_ptr)
					$display("ERROR enq_buf_ptr got %h expected %h",
						got.buf_ptr, want.buf_ptr);
				if (got.ptr_update !== want.ptr_update)
					$display("ERROR enq_ptr_update got %h expected %h",
						got.ptr_update, want.ptr_update);
				if (got.pd_update !== want.pd_update)
					$display("ERROR enq_pd_update got %h expected %h",
						got.pd_update, want.pd_update);
			end
			2: $display("ERROR classifier_fid got %h expected %h", got.cls_fid, want.cls_fid);
			default: begin
				if (got.tset_waddr !== want.tset_waddr)
					$display("ERROR tset_waddr got %h expected %h",
						got.tset_waddr, want.tset_waddr);
				if (got.tset_wdata !== want.tset_wdata)
					$display("ERROR tset_wdata got %h expected %h",
						got.tset_wdata, want.tset_wdata);
			end
		endcase
	endtask

	a_strobes: assert property (@(posedge clk) disable iff (!rst_n)
		{obs.valid, obs.cls_valid, obs.tset_wr} == {chk.valid, chk.cls_valid, chk.tset_wr})
		else begin
			value_errors++;
			report_diff(0, $sampled(obs), $sampled(chk));
		end

	a_enq: assert property (@(posedge clk) disable iff (!rst_n) chk.valid |->
		{obs.discard, obs.mcast, obs.vec, obs.pri, obs.tid, obs.buf_ptr, obs.ptr_update,
		obs.pd_update} == {chk.discard, chk.mcast, chk.vec, chk.pri, chk.tid, chk.buf_ptr,
		chk.ptr_update, chk.pd_update})
		else begin
			value_errors++;
			report_diff(1, $sampled(obs), $sampled(chk));
		end

	a_classifier: assert property (@(posedge clk) disable iff (!rst_n)
		chk.cls_valid |-> obs.cls_fid == chk.cls_fid)
		else begin
			value_errors++;
			report_diff(2, $sampled(obs), $sampled(chk));
		end

	a_expiry: assert property (@(posedge clk) disable iff (!rst_n)
		chk.tset_wr |-> {obs.tset_waddr, obs.tset_wdata} == {chk.tset_waddr, chk.tset_wdata})
		else begin
			value_errors++;
			report_diff(3, $sampled(obs), $sampled(chk));
		end

	task automatic idle_cycle();
		@(posedge clk);
		cycle++;
		proc_valid <= 1'b0;
		fp_wr <= 1'b0;
		expect_in <= '0;
		current_time <= current_time + $urandom_range(70000); // Time moves on idle cycles only.
	endtask

	task automatic write_policy(input logic [5:0] fid, input logic [14:0] data);
		@(posedge clk);
		cycle++;
		fp_wr <= 1'b1;
		fp_waddr <= fid;
		fp_wdata <= data;
		proc_valid <= 1'b0;
		expect_in <= '0;
		fp_shadow[fid] = data;
		if (fid_free[fid] < cycle + 2)
			fid_free[fid] = cycle + 2;
	endtask

	task automatic send_desc(input logic [5:0] fid, input logic [5:0] tid, input pkt_kind_e kind,
		input logic disc, input logic [45:0] ras);
		logic [2:0] rci;
		logic [3:0] dom;
		logic [11:0] bp;
		result_t r;
		rci = 3'($urandom);
		dom = $urandom_range(1) ? fp_shadow[fid][6:3] : 4'($urandom); // Half of them match.
		bp = 12'($urandom);
		predict(kind, fid, tid, rci, disc, dom, bp, ras, r);
		@(posedge clk);
		cycle++;
		proc_valid <= 1'b1;
		proc_kind <= kind;
		proc_fid <= fid;
		proc_tid <= tid;
		proc_rci <= rci;
		proc_discard <= disc;
		proc_domain_id <= dom;
		proc_buf_ptr <= bp;
		proc_ras <= ras;
		fp_wr <= 1'b0;
		expect_in <= r;
		fid_free[fid] = cycle + 4;
		tid_free[tid] = cycle + 4;
		n_sent++;
	endtask

	task automatic print_counts();
		$display("Errors: %0d value, %0d other, over %0d descriptors", value_errors,
			other_errors, n_sent);
	endtask

	initial begin
		logic [45:0] ras;
		logic [5:0] fid;
		logic [5:0] tid;
		void'($urandom(44));
		rst_n <= 1'b0;
		current_time <= $urandom;
		default_sub_exp_time <= 16'($urandom);
		supervisor_sci <= 3'($urandom);
		class2pri <= 16'($urandom);
		fp_wr <= 1'b0;
		fp_waddr <= '0;
		fp_wdata <= '0;
		proc_valid <= 1'b0;
		proc_kind <= pkt_normal;
		proc_fid <= '0;
		proc_tid <= '0;
		proc_rci <= '0;
		proc_discard <= 1'b0;
		proc_domain_id <= '0;
		proc_buf_ptr <= '0;
		proc_ras <= '0;
		expect_in <= '0;
		for (int i = 0; i < 64; i++) begin
			ta_shadow[i] = 8'h00;
			fid_free[i] = 0;
			tid_free[i] = 0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// Seeding needs update_fas and execute_forward in every policy.
		for (int f = 0; f < 64; f++)
			write_policy(6'(f), 15'($urandom) | 15'h0500);
		idle_cycle();
		idle_cycle();

		// A full flow action write per flow, with no read of the stored entry.
		for (int f = 0; f < 64; f++) begin
			ras = 46'({$urandom, $urandom});
			ras[2:0] = 3'b110;
			ras[5] = 1'b1;
			ras[9:8] = 2'b11;
			ras[13] = 1'b0;
			send_desc(6'(f), 6'(f), pkt_normal, 1'b0, ras);
		end

		for (int n = 0; n < n_random; n++) begin
			fid = 6'($urandom);
			tid = 6'($urandom);
			if ($urandom_range(9) == 0)
				write_policy(fid, 15'($urandom));
			else if ($urandom_range(9) == 0 || fid_free[fid] > cycle + 1 ||
				tid_free[tid] > cycle + 1)
				idle_cycle();
			else
				send_desc(fid, tid, pkt_kind_e'($urandom_range(2)), $urandom_range(7) == 0,
					46'({$urandom, $urandom}));
		end
		repeat (8) idle_cycle();

		if (n_enq != n_sent) begin
			other_errors++;
			$display("Saw %0d enqueue requests for %0d descriptors", n_enq, n_sent);
		end
		print_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end
endmodule

`default_nettype wire

// ==== source/asa_pkg.sv ====
/*
 * Widths, field positions, enums and the channel decode shared by the stage.
 * RAS layout: flag word in bits 9:0, then flow entries 0 to 7 and the topic
 * entry, four bits each with the invalid bit on top.
 */
`default_nettype none

package asa_pkg;
	localparam int sci_nbits = 3;
	localparam int sci_vec_nbits = 8;
	localparam int ras_flag_nbits = 10;
	localparam int ras_entry_nbits = 1 + sci_nbits;
	localparam int ras_nbits = ras_flag_nbits + 9 * ras_entry_nbits;
	localparam int flow_policy_nbits = 15;
	localparam int flow_action_nbits = 10; // Default type over the action vector.
	localparam int real_time_nbits = 32;
	localparam int sub_exp_time_nbits = 16;
	localparam int domain_nbits = 4;
	localparam int buf_ptr_nbits = 12;

	// Low bit of each flag word field.
	localparam int east_lsb = 0;
	localparam int ufdast_lsb = 3;
	localparam int uppp_bit = 6;
	localparam int uppd_bit = 7;
	localparam int nfascf_lsb = 8;
	localparam int topic_entry = 8; // The eight flow entries come first.

	// The flow policy word holds maskon over domain_id over tclass.
	localparam int fp_tclass_lsb = 0;
	localparam int fp_domain_lsb = 3;
	localparam int fp_maskon_lsb = 7;
	localparam int maskon_nbits = 8;
	localparam int tclass_nbits = 3;

	localparam int mo_update_ppd = 0;
	localparam int mo_update_fas = 1;
	localparam int mo_update_tas = 2;
	localparam int mo_execute_forward = 3;
	localparam int mo_fsas_forward = 4;
	localparam int mo_tsas_forward = 5;
	localparam int mo_multicast = 6;
	localparam int mo_forward_supervisor = 7;

	typedef enum logic [1:0] {pkt_normal, pkt_domain_checked, pkt_replay} pkt_kind_e;
	typedef enum logic [1:0] {set_discard, set_topic, set_flow, set_both} set_type_e;

	// An entry with its invalid bit set gives an empty vector.
	function automatic logic [sci_vec_nbits-1:0] sci_to_vec(
		input logic [ras_entry_nbits-1:0] entry
	);
		logic [sci_vec_nbits-1:0] vec;
		vec = '0;
		if (!entry[sci_nbits])
			vec[entry[sci_nbits-1:0]] = 1'b1;
		return vec;
	endfunction
endpackage

`default_nettype wire

// ==== source/asa_process.sv ====
/*
 * Pipeline control: table addressing, discard and forward decisions, table
 * updates and the topic expiry record. Three cycles from descriptor to output.
 * A descriptor that reuses a flow or topic id within 3 cycles sees stale tables.
 */
`timescale 1ns/1ps
`default_nettype none

module asa_process #(
	parameter int fid_nbits = 6,
	parameter int tid_nbits = 6
) (
	input wire clk,
	input wire rst_n,
	input wire [asa_pkg::real_time_nbits-1:0] current_time,
	input wire [asa_pkg::sub_exp_time_nbits-1:0] default_sub_exp_time,
	input wire fp_wr,
	input wire [fid_nbits-1:0] fp_waddr,
	input wire [asa_pkg::flow_policy_nbits-1:0] fp_wdata,
	input wire proc_valid,
	input wire asa_pkg::pkt_kind_e proc_kind,
	input wire [fid_nbits-1:0] proc_fid,
	input wire [tid_nbits-1:0] proc_tid,
	input wire [asa_pkg::sci_nbits-1:0] proc_rci,
	input wire proc_discard,
	input wire [asa_pkg::domain_nbits-1:0] proc_domain_id,
	input wire [asa_pkg::buf_ptr_nbits-1:0] proc_buf_ptr,
	input wire [asa_pkg::flow_policy_nbits-1:0] fp_rdata,
	input wire [asa_pkg::flow_action_nbits-1:0] fa_rdata,
	input wire [asa_pkg::sci_vec_nbits-1:0] ta_rdata,
	input wire [asa_pkg::sci_vec_nbits-1:0] flow_vec,
	input wire flow_any_valid,
	input wire [asa_pkg::sci_vec_nbits-1:0] topic_vec,
	input wire topic_valid,
	input wire [asa_pkg::sci_nbits-1:0] topic_sci,
	input wire [2:0] east,
	input wire [2:0] ufdast,
	input wire uppp,
	input wire uppd,
	input wire [1:0] nfascf,
	output logic [fid_nbits-1:0] fp_raddr,
	output logic [fid_nbits-1:0] fa_raddr,
	output logic [tid_nbits-1:0] ta_raddr,
	output logic fp_wr_q,
	output logic [fid_nbits-1:0] fp_waddr_q,
	output logic [asa_pkg::flow_policy_nbits-1:0] fp_wdata_q,
	output logic fa_wr,
	output logic [fid_nbits-1:0] fa_waddr,
	output logic [asa_pkg::flow_action_nbits-1:0] fa_wdata,
	output logic ta_wr,
	output logic [tid_nbits-1:0] ta_waddr,
	output logic [asa_pkg::sci_vec_nbits-1:0] ta_wdata,
	output logic fwd_valid,
	output logic fwd_discard,
	output logic [asa_pkg::sci_vec_nbits-1:0] fwd_src_vec,
	output logic [asa_pkg::sci_nbits-1:0] fwd_rci,
	output logic [asa_pkg::maskon_nbits-1:0] fwd_maskon,
	output logic [asa_pkg::tclass_nbits-1:0] fwd_tclass,
	output logic [tid_nbits-1:0] fwd_tid,
	output logic [asa_pkg::buf_ptr_nbits-1:0] fwd_buf_ptr,
	output logic fwd_ptr_update,
	output logic fwd_pd_update,
	output logic classifier_valid,
	output logic [fid_nbits-1:0] classifier_fid,
	output logic tset_wr,
	output logic [tid_nbits+asa_pkg::sci_nbits-1:0] tset_waddr,
	output logic [asa_pkg::sub_exp_time_nbits-1:0] tset_wdata
);
	import asa_pkg::*;

	logic valid_q1, valid_q2;
	pkt_kind_e kind_q1, kind_q2;
	logic [fid_nbits-1:0] fid_q1, fid_q2;
	logic [tid_nbits-1:0] tid_q1, tid_q2;
	logic [sci_nbits-1:0] rci_q1, rci_q2;
	logic discard_q1, discard_q2;
	logic [domain_nbits-1:0] domain_q1, domain_q2;
	logic [buf_ptr_nbits-1:0] buf_ptr_q1, buf_ptr_q2;
	logic [real_time_nbits-1:0] time_q1;
	logic [real_time_nbits-1:0] exp_sum;
	logic [sub_exp_time_nbits-1:0] exp_time_q2;
	logic [flow_policy_nbits-1:0] fp_q;
	logic [flow_action_nbits-1:0] fa_q;
	logic [sci_vec_nbits-1:0] ta_q;

	logic [maskon_nbits-1:0] maskon;
	logic is_replay, domain_discard, early_discard, upd_ok;
	logic execute_flow, execute_topic, use_eflow;
	logic fa_vec_wr, fa_type_wr;
	set_type_e stored_type, new_type;
	logic [sci_vec_nbits-1:0] stored_flow_vec, live_src_vec, replay_src_vec;

	// All three tables are looked up in the descriptor's own cycle.
	assign fp_raddr = proc_fid;
	assign fa_raddr = proc_fid;
	assign ta_raddr = proc_tid;

	// Expiry is current time plus the default shifted into the upper half.
	assign exp_sum = time_q1 +
		{default_sub_exp_time, {(real_time_nbits - sub_exp_time_nbits){1'b0}}};

	always_ff @(posedge clk) begin
		fp_waddr_q <= fp_waddr;
		fp_wdata_q <= fp_wdata;
		time_q1 <= current_time;
		kind_q1 <= proc_kind;
		fid_q1 <= proc_fid;
		tid_q1 <= proc_tid;
		rci_q1 <= proc_rci;
		discard_q1 <= proc_discard;
		domain_q1 <= proc_domain_id;
		buf_ptr_q1 <= proc_buf_ptr;
		kind_q2 <= kind_q1;
		fid_q2 <= fid_q1;
		tid_q2 <= tid_q1;
		rci_q2 <= rci_q1;
		discard_q2 <= discard_q1;
		domain_q2 <= domain_q1;
		buf_ptr_q2 <= buf_ptr_q1;
		exp_time_q2 <= exp_sum[real_time_nbits-1:sub_exp_time_nbits];
		fp_q <= fp_rdata;
		fa_q <= fa_rdata;
		ta_q <= ta_rdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fp_wr_q <= 1'b0;
			valid_q1 <= 1'b0;
			valid_q2 <= 1'b0;
		end else begin
			fp_wr_q <= fp_wr;
			valid_q1 <= proc_valid;
			valid_q2 <= valid_q1;
		end
	end

	assign maskon = fp_q[fp_maskon_lsb +: maskon_nbits];
	assign is_replay = kind_q2 == pkt_replay;
	assign domain_discard = (kind_q2 == pkt_domain_checked) &&
		(domain_q2 != fp_q[fp_domain_lsb +: domain_nbits]);
	assign early_discard = discard_q2 | domain_discard;
	assign upd_ok = valid_q2 & ~early_discard & ~is_replay;
	assign execute_flow = east[1];
	assign execute_topic = east[0];

	assign stored_type = set_type_e'(fa_q[flow_action_nbits-1:sci_vec_nbits]);
	assign stored_flow_vec = fa_q[sci_vec_nbits-1:0];
	assign new_type = ufdast[2] ? set_type_e'(ufdast[1:0]) : stored_type;

	// Flow action update. The vector needs nfascf 11 and a valid flow entry.
	assign fa_vec_wr = upd_ok & execute_flow & (nfascf == 2'b11) & flow_any_valid &
		maskon[mo_update_fas];
	assign fa_type_wr = upd_ok & ufdast[2] & maskon[mo_update_fas];
	assign fa_wr = fa_vec_wr | fa_type_wr;
	assign fa_waddr = fid_q2;
	assign fa_wdata = {new_type, fa_vec_wr ? flow_vec : stored_flow_vec};

	assign ta_wr = upd_ok & execute_topic & topic_valid & maskon[mo_update_tas];
	assign ta_waddr = tid_q2;
	assign ta_wdata = ta_q | topic_vec; // New subscriber joins the stored set.

	assign use_eflow = nfascf[1] & execute_flow & maskon[mo_execute_forward];

	always_comb begin
		live_src_vec = '0;
		if (execute_topic && maskon[mo_execute_forward])
			live_src_vec = live_src_vec | topic_vec;
		if (use_eflow)
			live_src_vec = live_src_vec | flow_vec;
		if (execute_topic && maskon[mo_tsas_forward])
			live_src_vec = live_src_vec | ta_q;
		if (!use_eflow && maskon[mo_fsas_forward])
			live_src_vec = live_src_vec | stored_flow_vec;
		// Replay packets use only the stored sets named by the default type.
		replay_src_vec = '0;
		if ((stored_type == set_topic || stored_type == set_both) && maskon[mo_tsas_forward])
			replay_src_vec = replay_src_vec | ta_q;
		if ((stored_type == set_flow || stored_type == set_both) && maskon[mo_fsas_forward])
			replay_src_vec = replay_src_vec | stored_flow_vec;
	end

	assign fwd_valid = valid_q2;
	assign fwd_discard = early_discard |
		(is_replay ? (stored_type == set_discard) : (east[1:0] == 2'b00));
	assign fwd_src_vec = is_replay ? replay_src_vec : live_src_vec;
	assign fwd_rci = rci_q2;
	assign fwd_maskon = maskon;
	assign fwd_tclass = fp_q[fp_tclass_lsb +: tclass_nbits];
	assign fwd_tid = tid_q2;
	assign fwd_buf_ptr = buf_ptr_q2;
	assign fwd_ptr_update = ~is_replay & uppp;
	assign fwd_pd_update = ~is_replay & maskon[mo_update_ppd] & uppd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			classifier_valid <= 1'b0;
			tset_wr <= 1'b0;
		end else begin
			classifier_valid <= valid_q2 & ~east[2]; // Flow ends here, tell the classifier.
			tset_wr <= ta_wr;
		end
	end

	always_ff @(posedge clk) begin
		classifier_fid <= fid_q2;
		tset_waddr <= {tid_q2, topic_sci};
		tset_wdata <= exp_time_q2;
	end
endmodule

`default_nettype wire

// ==== source/asa_top.sv ====
/*
 * Action-set stage of the pub/sub switch. One descriptor per cycle, outputs
 * three cycles later, no back-pressure. Tables are undefined until written,
 * and a policy write reaches reads sampled two or more cycles after it.
 */
`timescale 1ns/1ps
`default_nettype none

module asa_top #(
	parameter int fid_nbits = 6,
	parameter int tid_nbits = 6
) (
	input wire clk,
	input wire rst_n,
	input wire [asa_pkg::real_time_nbits-1:0] current_time,
	input wire [asa_pkg::sub_exp_time_nbits-1:0] default_sub_exp_time,
	input wire [asa_pkg::sci_nbits-1:0] supervisor_sci,
	input wire [15:0] class2pri,
	input wire fp_wr,
	input wire [fid_nbits-1:0] fp_waddr,
	input wire [asa_pkg::flow_policy_nbits-1:0] fp_wdata,
	input wire proc_valid,
	input wire asa_pkg::pkt_kind_e proc_kind,
	input wire [fid_nbits-1:0] proc_fid,
	input wire [tid_nbits-1:0] proc_tid,
	input wire [asa_pkg::sci_nbits-1:0] proc_rci,
	input wire proc_discard,
	input wire [asa_pkg::domain_nbits-1:0] proc_domain_id,
	input wire [asa_pkg::buf_ptr_nbits-1:0] proc_buf_ptr,
	input wire [asa_pkg::ras_nbits-1:0] proc_ras,
	output wire classifier_valid,
	output wire [fid_nbits-1:0] classifier_fid,
	output wire tset_wr,
	output wire [tid_nbits+asa_pkg::sci_nbits-1:0] tset_waddr,
	output wire [asa_pkg::sub_exp_time_nbits-1:0] tset_wdata,
	output wire enq_req,
	output wire enq_discard,
	output wire enq_allow_mcast,
	output wire [asa_pkg::sci_vec_nbits-1:0] enq_vec,
	output wire [1:0] enq_pri,
	output wire [tid_nbits-1:0] enq_tid,
	output wire [asa_pkg::buf_ptr_nbits-1:0] enq_buf_ptr,
	output wire enq_ptr_update,
	output wire enq_pd_update
);
	import asa_pkg::*;

	wire [fid_nbits-1:0] fp_raddr, fa_raddr, fp_waddr_q, fa_waddr;
	wire [tid_nbits-1:0] ta_raddr, ta_waddr, fwd_tid;
	wire [flow_policy_nbits-1:0] fp_rdata, fp_wdata_q;
	wire [flow_action_nbits-1:0] fa_rdata, fa_wdata;
	wire [sci_vec_nbits-1:0] ta_rdata, ta_wdata;
	wire [sci_vec_nbits-1:0] flow_vec, topic_vec, fwd_src_vec;
	wire fp_wr_q, fa_wr, ta_wr;
	wire flow_any_valid, topic_valid, uppp, uppd;
	wire [sci_nbits-1:0] topic_sci, fwd_rci;
	wire [2:0] east, ufdast;
	wire [1:0] nfascf;
	wire fwd_valid, fwd_discard, fwd_ptr_update, fwd_pd_update;
	wire [maskon_nbits-1:0] fwd_maskon;
	wire [tclass_nbits-1:0] fwd_tclass;
	wire [buf_ptr_nbits-1:0] fwd_buf_ptr;

	// Flow policy, written only by the configuration port.
	ram_1r1w #(.width(flow_policy_nbits), .addr_nbits(fid_nbits)) u_fp_table (
		.clk(clk),
		.wr(fp_wr_q),
		.waddr(fp_waddr_q),
		.din(fp_wdata_q),
		.raddr(fp_raddr),
		.dout(fp_rdata)
	);

	ram_1r1w #(.width(flow_action_nbits), .addr_nbits(fid_nbits)) u_fa_table (
		.clk(clk),
		.wr(fa_wr),
		.waddr(fa_waddr),
		.din(fa_wdata),
		.raddr(fa_raddr),
		.dout(fa_rdata)
	);

	ram_1r1w #(.width(sci_vec_nbits), .addr_nbits(tid_nbits)) u_ta_table (
		.clk(clk),
		.wr(ta_wr),
		.waddr(ta_waddr),
		.din(ta_wdata),
		.raddr(ta_raddr),
		.dout(ta_rdata)
	);

	ras_decoder u_ras_decoder (
		.ras(proc_ras),
		.*
	);

	asa_process #(.fid_nbits(fid_nbits), .tid_nbits(tid_nbits)) u_asa_process (.*);

	enq_formatter #(.tid_nbits(tid_nbits)) u_enq_formatter (.*);
endmodule

`default_nettype wire

// ==== source/enq_formatter.sv ====
/*
 * Final stage toward the replication queue. Masks the receive channel and
 * the supervisor channel out of the forward vector and maps tclass to a
 * priority. class2pri holds eight 2-bit priorities, class 0 in bits 1:0.
 */
`timescale 1ns/1ps
`default_nettype none

module enq_formatter #(
	parameter int tid_nbits = 6
) (
	input wire clk,
	input wire rst_n,
	input wire [asa_pkg::sci_nbits-1:0] supervisor_sci,
	input wire [15:0] class2pri,
	input wire fwd_valid,
	input wire fwd_discard,
	input wire [asa_pkg::sci_vec_nbits-1:0] fwd_src_vec,
	input wire [asa_pkg::sci_nbits-1:0] fwd_rci,
	input wire [asa_pkg::maskon_nbits-1:0] fwd_maskon,
	input wire [asa_pkg::tclass_nbits-1:0] fwd_tclass,
	input wire [tid_nbits-1:0] fwd_tid,
	input wire [asa_pkg::buf_ptr_nbits-1:0] fwd_buf_ptr,
	input wire fwd_ptr_update,
	input wire fwd_pd_update,
	output logic enq_req,
	output logic enq_discard,
	output logic enq_allow_mcast,
	output logic [asa_pkg::sci_vec_nbits-1:0] enq_vec,
	output logic [1:0] enq_pri,
	output logic [tid_nbits-1:0] enq_tid,
	output logic [asa_pkg::buf_ptr_nbits-1:0] enq_buf_ptr,
	output logic enq_ptr_update,
	output logic enq_pd_update
);
	import asa_pkg::*;

	logic [sci_vec_nbits-1:0] rci_mask;
	logic [sci_vec_nbits-1:0] sup_mask;
	logic [1:0] pri;

	// A packet never goes back out on the channel it came in on.
	assign rci_mask = ~sci_to_vec({1'b0, fwd_rci});
	assign sup_mask = fwd_maskon[mo_forward_supervisor] ? '1 :
		~sci_to_vec({1'b0, supervisor_sci});
	assign pri = class2pri[{fwd_tclass, 1'b0} +: 2];

	always_ff @(posedge clk) begin
		enq_discard <= fwd_discard;
		enq_allow_mcast <= fwd_maskon[mo_multicast];
		enq_vec <= fwd_src_vec & rci_mask & sup_mask;
		enq_pri <= pri;
		enq_tid <= fwd_tid;
		enq_buf_ptr <= fwd_buf_ptr;
		enq_ptr_update <= fwd_ptr_update;
		enq_pd_update <= fwd_pd_update;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			enq_req <= 1'b0;
		else
			enq_req <= fwd_valid; // One strobe per descriptor, no back-pressure.
	end
endmodule

`default_nettype wire

// ==== source/ram_1r1w.sv ====
/*
 * Table with one synchronous write port and one registered read port.
 * A read of the word written on the same edge returns the old contents.
 * Contents are undefined until written.
 */
`timescale 1ns/1ps
`default_nettype none

module ram_1r1w #(
	parameter int width = 8,
	parameter int addr_nbits = 6
) (
	input wire clk,
	input wire wr,
	input wire [addr_nbits-1:0] waddr,
	input wire [width-1:0] din,
	input wire [addr_nbits-1:0] raddr,
	output logic [width-1:0] dout
);
	logic [width-1:0] mem [0:(1 << addr_nbits)-1];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
		dout <= mem[raddr]; // Read data appears one cycle after the address.
	end
endmodule

`default_nettype wire

// ==== source/ras_decoder.sv ====
/*
 * Registers the RAS once, decodes it, and registers the result again so the
 * fields line up with stage 2 of the control pipeline.
 * Only the valid flags are reset.
 */
`timescale 1ns/1ps
`default_nettype none

module ras_decoder (
	input wire clk,
	input wire rst_n,
	input wire [asa_pkg::ras_nbits-1:0] ras,
	output logic [asa_pkg::sci_vec_nbits-1:0] flow_vec,
	output logic flow_any_valid,
	output logic [asa_pkg::sci_vec_nbits-1:0] topic_vec,
	output logic topic_valid,
	output logic [asa_pkg::sci_nbits-1:0] topic_sci,
	output logic [2:0] east,
	output logic [2:0] ufdast,
	output logic uppp,
	output logic uppd,
	output logic [1:0] nfascf
);
	import asa_pkg::*;

	logic [ras_nbits-1:0] ras_q;
	logic [ras_entry_nbits-1:0] topic_ent;
	logic [sci_vec_nbits-1:0] flow_vec_c;
	logic flow_any_c;

	assign topic_ent = ras_q[ras_flag_nbits + topic_entry * ras_entry_nbits +: ras_entry_nbits];

	// All valid flow entries merge into one forward vector.
	always_comb begin
		logic [ras_entry_nbits-1:0] ent;
		flow_vec_c = '0;
		flow_any_c = 1'b0;
		for (int i = 0; i < topic_entry; i++) begin
			ent = ras_q[ras_flag_nbits + i * ras_entry_nbits +: ras_entry_nbits];
			flow_vec_c = flow_vec_c | sci_to_vec(ent);
			flow_any_c = flow_any_c | ~ent[sci_nbits];
		end
	end

	always_ff @(posedge clk) begin
		ras_q <= ras;
		flow_vec <= flow_vec_c;
		topic_vec <= sci_to_vec(topic_ent);
		topic_sci <= topic_ent[sci_nbits-1:0];
		east <= ras_q[east_lsb +: 3];
		ufdast <= ras_q[ufdast_lsb +: 3];
		uppp <= ras_q[uppp_bit];
		uppd <= ras_q[uppd_bit];
		nfascf <= ras_q[nfascf_lsb +: 2];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flow_any_valid <= 1'b0;
			topic_valid <= 1'b0;
		end else begin
			flow_any_valid <= flow_any_c;
			topic_valid <= ~topic_ent[sci_nbits];
		end
	end
endmodule

`default_nettype wire
